/* compile.f */
+incdir+tests
src/mem_bridge_pkg.sv
src/sram_halfword.sv
src/mem_data_lanes.sv
src/memory_interface.sv
src/mem_subsystem.sv
tests/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_bridge

sources:
  - src/mem_bridge_pkg.sv
  - src/sram_halfword.sv
  - src/mem_data_lanes.sv
  - src/memory_interface.sv
  - src/mem_subsystem.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_mem_subsystem.sv

/* tests/tb_vectors.svh */
/* directed stimulus table for the bridge testbench:
   row arrays, op codes and the rows with their expected load data */

`ifndef tb_vectors_svh
`define tb_vectors_svh

localparam int num_rows = 33;

// op codes, poke variants send stray requests while busy
localparam int op_store      = 0;
localparam int op_load       = 1;
localparam int op_store_poke = 2;
localparam int op_load_poke  = 3;

localparam mem_bridge_pkg::access_size_t sz_b = mem_bridge_pkg::size_byte;
localparam mem_bridge_pkg::access_size_t sz_h = mem_bridge_pkg::size_half;
localparam mem_bridge_pkg::access_size_t sz_w = mem_bridge_pkg::size_word;

string                        row_name   [num_rows];
int                           row_op     [num_rows];
logic [addr_width:0]          row_addr   [num_rows];
mem_bridge_pkg::access_size_t row_size   [num_rows];
bit                           row_sign   [num_rows];
mem_bridge_pkg::word_t        row_wdata  [num_rows];
mem_bridge_pkg::word_t        row_expect [num_rows];
int                           row_count = 0;

task automatic add_row(input string name, input int op, input logic [addr_width:0] addr,
                       input mem_bridge_pkg::access_size_t sz, input bit sgn,
                       input mem_bridge_pkg::word_t wdata, input mem_bridge_pkg::word_t exp_data);
  row_name[row_count]   = name;
  row_op[row_count]     = op;
  row_addr[row_count]   = addr;
  row_size[row_count]   = sz;
  row_sign[row_count]   = sgn;
  row_wdata[row_count]  = wdata;
  row_expect[row_count] = exp_data;
  row_count++;
endtask

task automatic fill_table();
  // aligned word, then every lane with both extensions
  add_row("st w 010",        op_store, 13'h0010, sz_w, 0, 32'h80007f80, 32'h00000000);
  add_row("ld w 010",        op_load,  13'h0010, sz_w, 0, 32'h0,        32'h80007f80);
  add_row("ld b 010 u",      op_load,  13'h0010, sz_b, 0, 32'h0,        32'h00000080);
  add_row("ld b 010 s",      op_load,  13'h0010, sz_b, 1, 32'h0,        32'hffffff80);
  add_row("ld b 011 s",      op_load,  13'h0011, sz_b, 1, 32'h0,        32'h0000007f);
  add_row("ld h 010 s",      op_load,  13'h0010, sz_h, 1, 32'h0,        32'h00007f80);
  add_row("ld h 012 u",      op_load,  13'h0012, sz_h, 0, 32'h0,        32'h00008000);
  add_row("ld h 012 s",      op_load,  13'h0012, sz_h, 1, 32'h0,        32'hffff8000);
  add_row("ld b 013 s",      op_load,  13'h0013, sz_b, 1, 32'h0,        32'hffffff80);
  // read-modify-write keeps the neighbours
  add_row("st w 020",        op_store, 13'h0020, sz_w, 0, 32'h44332211, 32'h0);
  add_row("st w 024",        op_store, 13'h0024, sz_w, 0, 32'h88776655, 32'h0);
  add_row("st b 021",        op_store, 13'h0021, sz_b, 0, 32'h000000aa, 32'h0);
  add_row("ld w 020 a",      op_load,  13'h0020, sz_w, 0, 32'h0,        32'h4433aa11);
  add_row("st h 023",        op_store, 13'h0023, sz_h, 0, 32'h0000ccbb, 32'h0);
  add_row("ld w 020 b",      op_load,  13'h0020, sz_w, 0, 32'h0,        32'hbb33aa11);
  add_row("ld w 024 a",      op_load,  13'h0024, sz_w, 0, 32'h0,        32'h887766cc);
  add_row("st w 028",        op_store, 13'h0028, sz_w, 0, 32'h0d0c0b0a, 32'h0);
  add_row("st w 025",        op_store, 13'h0025, sz_w, 0, 32'hf4f3f2f1, 32'h0);
  add_row("ld w 024 b",      op_load,  13'h0024, sz_w, 0, 32'h0,        32'hf3f2f1cc);
  add_row("ld w 028",        op_load,  13'h0028, sz_w, 0, 32'h0,        32'h0d0c0bf4);
  add_row("ld w 025",        op_load,  13'h0025, sz_w, 1, 32'h0,        32'hf4f3f2f1);
  add_row("ld h 027 s",      op_load,  13'h0027, sz_h, 1, 32'h0,        32'hfffff4f3);
  // misaligned word at the top byte wraps to bytes 0..2
  add_row("st w 1ffc",       op_store, 13'h1ffc, sz_w, 0, 32'h5a5a5a5a, 32'h0);
  add_row("st w 000",        op_store, 13'h0000, sz_w, 0, 32'h03020100, 32'h0);
  add_row("st w 1fff",       op_store, 13'h1fff, sz_w, 0, 32'hc3c2c1c0, 32'h0);
  add_row("ld w 1ffc",       op_load,  13'h1ffc, sz_w, 0, 32'h0,        32'hc05a5a5a);
  add_row("ld w 000",        op_load,  13'h0000, sz_w, 0, 32'h0,        32'h03c3c2c1);
  add_row("ld w 1fff",       op_load,  13'h1fff, sz_w, 0, 32'h0,        32'hc3c2c1c0);
  // stray requests aimed at 0x100 must not land
  add_row("st w 100",        op_store,      13'h0100, sz_w, 0, 32'h12345678, 32'h0);
  add_row("ld w 010 poke",   op_load_poke,  13'h0010, sz_w, 0, 32'ha5a5a5a5, 32'h80007f80);
  add_row("st h 030 poke",   op_store_poke, 13'h0030, sz_h, 0, 32'h0000beef, 32'h0);
  add_row("ld h 030",        op_load,       13'h0030, sz_h, 0, 32'h0,        32'h0000beef);
  add_row("ld w 100",        op_load,       13'h0100, sz_w, 0, 32'h0,        32'h12345678);
endtask

`endif

/* tests/tb_mem_subsystem.sv */
/* halfword memory bridge testbench with directed table, random phase
   against a byte-array model, latency and busy checks and watchdog */

`default_nettype none

module tb_mem_subsystem;

  localparam int addr_width     = 12;
  localparam int mem_bytes      = 2 ** (addr_width + 1);
  localparam int num_random     = 200;
  localparam int max_wait       = 16;
  localparam logic [addr_width:0] stray_addr = 13'h0100;

  `include "tb_vectors.svh"

  localparam int timeout_cycles = (num_rows + num_random) * 10 + 50;

  logic                         clk = 1'b0;
  logic                         rst;
  logic [addr_width:0]          address;
  mem_bridge_pkg::word_t        data_in;
  logic                         load;
  logic                         store;
  logic                         is_signed;
  mem_bridge_pkg::access_size_t word_type;
  mem_bridge_pkg::word_t        data_out;
  logic                         output_valid;
  logic                         write_ready;
  logic                         busy;

  // little-endian byte model
  // known marks the bytes written so far
  logic [7:0] model_mem   [mem_bytes];
  bit         model_known [mem_bytes];

  int     check_errors = 0;
  int     other_errors = 0;
  int     cycle_count  = 0;
  bit     waiting      = 1'b0;
  integer seed         = 32'h5673;

  mem_subsystem #(
    .addr_width (addr_width)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .address      (address),
    .data_in      (data_in),
    .load         (load),
    .store        (store),
    .is_signed    (is_signed),
    .word_type    (word_type),
    .data_out     (data_out),
    .output_valid (output_valid),
    .write_ready  (write_ready),
    .busy         (busy)
  );

  always #2 clk = ~clk;

  // ####################
  // watchdog and monitor
  // ####################

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("ERROR: run did not finish within %0d cycles", timeout_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // done pulses only belong inside an access
  always @(negedge clk) begin
    if (!rst && !waiting && (output_valid || write_ready)) begin
      other_errors++;
      $display("ERROR: done pulse at cycle %0d with no access pending", cycle_count);
    end
  end

  // ####################
  // compare tasks
  // ####################

  task automatic check_word(input string name, input mem_bridge_pkg::word_t exp_val,
                            input mem_bridge_pkg::word_t act_val);
    if (act_val !== exp_val) begin
      check_errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_latency(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      check_errors++;
      $display("CHECK FAILED %s latency expected %0d actual %0d", name, exp_val, act_val);
    end
  endtask

  // ####################
  // reference rules
  // ####################

  function automatic int byte_count(input mem_bridge_pkg::access_size_t sz);
    case (sz)
      mem_bridge_pkg::size_byte: return 1;
      mem_bridge_pkg::size_half: return 2;
      default:                   return 4;
    endcase
  endfunction

  // halfwords touched by an access
  function automatic int halfwords_touched(input mem_bridge_pkg::access_size_t sz,
                                           input logic odd);
    case (sz)
      mem_bridge_pkg::size_byte: return 1;
      mem_bridge_pkg::size_half: return odd ? 2 : 1;
      default:                   return odd ? 3 : 2;
    endcase
  endfunction

  task automatic model_store(input logic [addr_width:0] addr,
                             input mem_bridge_pkg::access_size_t sz,
                             input mem_bridge_pkg::word_t wdata);
    int i;
    int idx;
    for (i = 0; i < byte_count(sz); i++) begin
      idx = (int'(addr) + i) % mem_bytes;
      model_mem[idx]   = wdata[i*8 +: 8];
      model_known[idx] = 1'b1;
    end
  endtask

  // expected load value from the byte model
  // mask covers only the bits that depend on written bytes
  task automatic model_expect(input logic [addr_width:0] addr,
                              input mem_bridge_pkg::access_size_t sz, input bit sgn,
                              output mem_bridge_pkg::word_t value,
                              output mem_bridge_pkg::word_t mask);
    int i;
    int b;
    int idx;
    int nbytes;
    logic top_bit;
    logic top_known;
    nbytes = byte_count(sz);
    value  = '0;
    mask   = '0;
    for (i = 0; i < nbytes; i++) begin
      idx = (int'(addr) + i) % mem_bytes;
      value[i*8 +: 8] = model_mem[idx];
      mask[i*8 +: 8]  = model_known[idx] ? 8'hff : 8'h00;
    end
    top_bit   = value[nbytes*8-1];
    top_known = mask[nbytes*8-1];
    // extension bits follow the top byte when signed
    for (b = nbytes * 8; b < 32; b++) begin
      value[b] = sgn ? top_bit : 1'b0;
      mask[b]  = sgn ? top_known : 1'b1;
    end
  endtask

  // ####################
  // one bus access
  // ####################

  task automatic run_access(input string name, input bit is_ld,
                            input logic [addr_width:0] addr,
                            input mem_bridge_pkg::access_size_t sz, input bit sgn,
                            input mem_bridge_pkg::word_t wdata, input bit poke,
                            output mem_bridge_pkg::word_t result);
    int  c;
    int  exp_lat;
    bit  done;
    exp_lat = is_ld ? halfwords_touched(sz, addr[0]) + 1
                    : 2 * halfwords_touched(sz, addr[0]) + 1;
    result  = '0;
    @(posedge clk);
    address   <= addr;
    data_in   <= wdata;
    load      <= is_ld;
    store     <= !is_ld;
    word_type <= sz;
    is_signed <= sgn;
    @(negedge clk);
    if (busy) begin
      other_errors++;
      $display("ERROR: %s busy was high when the request was applied", name);
    end
    // accept edge
    @(posedge clk);
    waiting = 1'b1;
    load  <= 1'b0;
    store <= 1'b0;
    // stray store in cycle 1 and stray load in cycle 2 with data_in unchanged
    if (poke) begin
      store     <= 1'b1;
      address   <= stray_addr;
      word_type <= mem_bridge_pkg::size_word;
    end
    c    = 1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (!busy) begin
        other_errors++;
        $display("ERROR: %s busy low in cycle %0d of the access", name, c);
      end
      if (is_ld ? write_ready : output_valid) begin
        other_errors++;
        $display("ERROR: %s got the done pulse of the other access kind", name);
      end
      if (is_ld ? output_valid : write_ready) begin
        done   = 1'b1;
        result = data_out;
      end else if (c >= max_wait) begin
        other_errors++;
        $display("ERROR: %s no done pulse within %0d cycles", name, max_wait);
        done = 1'b1;
      end else begin
        @(posedge clk);
        load  <= poke && (c == 1);
        store <= 1'b0;
        c++;
      end
    end
    check_latency(name, exp_lat, c);
    @(posedge clk);
    load    <= 1'b0;
    store   <= 1'b0;
    waiting = 1'b0;
  endtask

  // ####################
  // main sequence
  // ####################

  initial begin
    int                           i;
    int                           r_op;
    int                           r_addr;
    int                           r_size;
    int                           r_data;
    int                           pick;
    bit                           is_ld;
    bit                           poke;
    logic [addr_width:0]          addr;
    mem_bridge_pkg::access_size_t sz;
    mem_bridge_pkg::word_t        result;
    mem_bridge_pkg::word_t        exp_val;
    mem_bridge_pkg::word_t        mask;
    mem_bridge_pkg::word_t        last_load;

    rst       = 1'b1;
    address   = '0;
    data_in   = '0;
    load      = 1'b0;
    store     = 1'b0;
    is_signed = 1'b0;
    word_type = mem_bridge_pkg::size_byte;
    last_load = '0;
    for (i = 0; i < mem_bytes; i++) begin
      model_known[i] = 1'b0;
    end
    fill_table();

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // outputs after reset
    @(negedge clk);
    if (busy || output_valid || write_ready) begin
      other_errors++;
      $display("ERROR: busy, output_valid or write_ready high after reset");
    end
    check_word("reset data_out", 32'h0, data_out);

    // directed table
    for (i = 0; i < num_rows; i++) begin
      is_ld = (row_op[i] == op_load) || (row_op[i] == op_load_poke);
      poke  = (row_op[i] == op_store_poke) || (row_op[i] == op_load_poke);
      run_access(row_name[i], is_ld, row_addr[i], row_size[i], row_sign[i],
                 row_wdata[i], poke, result);
      if (is_ld) begin
        check_word(row_name[i], row_expect[i], result);
        last_load = row_expect[i];
      end else begin
        // data_out keeps the last load result through a store
        check_word($sformatf("%s data_out hold", row_name[i]), last_load, result);
        model_store(row_addr[i], row_size[i], row_wdata[i]);
      end
    end

    // random phase on the low 64 bytes and the top 32 bytes
    for (i = 0; i < num_random; i++) begin
      r_op   = $random(seed);
      r_addr = $random(seed);
      r_size = $random(seed);
      r_data = $random(seed);
      pick   = $unsigned(r_addr) % 96;
      addr   = (pick < 64) ? pick : mem_bytes - 96 + pick;
      sz     = mem_bridge_pkg::access_size_t'($unsigned(r_size) % 3);
      is_ld  = r_op[0];
      run_access($sformatf("random %0d", i), is_ld, addr, sz, r_op[1], r_data, 1'b0,
                 result);
      if (is_ld) begin
        model_expect(addr, sz, r_op[1], exp_val, mask);
        check_word($sformatf("random %0d", i), exp_val & mask, result & mask);
      end else begin
        model_store(addr, sz, r_data);
      end
    end

    $display("errors: %0d value mismatches, %0d other failures", check_errors,
             other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/mem_subsystem.sv */
/* top level of the halfword memory bridge:
   memory interface, data lanes and halfword sram */

`default_nettype none

module mem_subsystem #(
  parameter int addr_width = 12
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [addr_width:0]           address,
  input  mem_bridge_pkg::word_t         data_in,
  input  wire                           load,
  input  wire                           store,
  input  wire                           is_signed,
  input  mem_bridge_pkg::access_size_t  word_type,
  output mem_bridge_pkg::word_t         data_out,
  output logic                          output_valid,
  output logic                          write_ready,
  output logic                          busy
);

  // ####################
  // internal nets
  // ####################

  // sram side
  logic                          to_mem_mem_enable;
  logic                          to_mem_read_enable;
  logic                          to_mem_write_enable;
  logic [addr_width-1:0]         to_mem_address;
  mem_bridge_pkg::halfword_t     to_mem_data;
  mem_bridge_pkg::halfword_t     from_mem_data;

  // sequencer to lanes
  logic                          capture;
  logic [1:0]                    slot;
  logic                          offset;
  mem_bridge_pkg::access_size_t  size;
  logic                          sign;
  logic                          finish_load;
  mem_bridge_pkg::halfword_t     write_half;

  memory_interface #(
    .addr_width (addr_width)
  ) i_memory_interface (
    .clk                 (clk),
    .rst                 (rst),
    .address             (address),
    .load                (load),
    .store               (store),
    .word_type           (word_type),
    .is_signed           (is_signed),
    .write_half          (write_half),
    .to_mem_mem_enable   (to_mem_mem_enable),
    .to_mem_read_enable  (to_mem_read_enable),
    .to_mem_write_enable (to_mem_write_enable),
    .to_mem_address      (to_mem_address),
    .to_mem_data         (to_mem_data),
    .capture             (capture),
    .slot                (slot),
    .offset              (offset),
    .size                (size),
    .sign                (sign),
    .finish_load         (finish_load),
    .output_valid        (output_valid),
    .write_ready         (write_ready),
    .busy                (busy)
  );

  mem_data_lanes i_mem_data_lanes (
    .clk           (clk),
    .rst           (rst),
    .capture       (capture),
    .slot          (slot),
    .offset        (offset),
    .size          (size),
    .sign          (sign),
    .finish_load   (finish_load),
    .from_mem_data (from_mem_data),
    .data_in       (data_in),
    .data_out      (data_out),
    .write_half    (write_half)
  );

  sram_halfword #(
    .addr_width (addr_width)
  ) i_sram_halfword (
    .clk          (clk),
    .mem_enable   (to_mem_mem_enable),
    .read_enable  (to_mem_read_enable),
    .write_enable (to_mem_write_enable),
    .address      (to_mem_address),
    .write_data   (to_mem_data),
    .read_data    (from_mem_data)
  );

endmodule

`default_nettype wire

/* src/memory_interface.sv */
/* request sequencer and address path of the bridge: direct, delayed and
   added address buffers, idle/read/write/done FSM with halfword counter */

`default_nettype none

module memory_interface #(
  parameter int addr_width = 12
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire  [addr_width:0]           address,
  input  wire                           load,
  input  wire                           store,
  input  mem_bridge_pkg::access_size_t  word_type,
  input  wire                           is_signed,
  input  mem_bridge_pkg::halfword_t     write_half,
  output logic                          to_mem_mem_enable,
  output logic                          to_mem_read_enable,
  output logic                          to_mem_write_enable,
  output logic [addr_width-1:0]         to_mem_address,
  output mem_bridge_pkg::halfword_t     to_mem_data,
  output logic                          capture,
  output logic [1:0]                    slot,
  output logic                          offset,
  output mem_bridge_pkg::access_size_t  size,
  output logic                          sign,
  output logic                          finish_load,
  output logic                          output_valid,
  output logic                          write_ready,
  output logic                          busy
);

  // counter holds 0 up to max_halfwords
  localparam int cnt_width = $clog2(mem_bridge_pkg::max_halfwords + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_done
  } state_t;

  state_t                 state;
  logic [cnt_width-1:0]   cnt;
  logic [cnt_width-1:0]   n_req;
  logic [cnt_width-1:0]   n_reg;
  logic                   is_load_reg;
  logic                   accept;

  // ####################
  // request decode
  // ####################

  assign busy   = (state != st_idle);
  assign accept = (load || store) && !busy;

  // halfwords touched, from size and byte offset
  always_comb begin
    case (word_type)
      mem_bridge_pkg::size_byte: n_req = cnt_width'(1);
      mem_bridge_pkg::size_half: n_req = address[0] ? cnt_width'(2) : cnt_width'(1);
      mem_bridge_pkg::size_word: n_req = address[0] ? cnt_width'(3) : cnt_width'(2);
      default:                   n_req = cnt_width'(1);
    endcase
  end

  // request attributes, held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      n_reg  <= n_req;
      offset <= address[0];
      size   <= word_type;
      sign   <= is_signed;
    end
  end

  // ####################
  // address path
  // ####################

  logic                   direct_sel;
  logic                   delayed_sel;
  logic                   summand_one_sel;
  logic [addr_width-1:0]  delayed_buf;
  logic [addr_width-1:0]  added_buf;
  logic [addr_width-1:0]  summand;
  logic [addr_width-1:0]  added_address;
  logic [addr_width-1:0]  modified_address;

  // both buffers take the halfword base at accept, else hold
  always_ff @(posedge clk) begin
    delayed_buf <= accept ? address[addr_width:1] : delayed_buf;
    added_buf   <= accept ? address[addr_width:1] : added_buf;
  end

  // slot 1 is base+1, slot 2 (the last of a misaligned word) is base+2
  assign summand_one_sel = (cnt != cnt_width'(2));
  assign summand         = summand_one_sel ? addr_width'(1) : addr_width'(2);
  assign added_address   = added_buf + summand;

  // cycle 0 reads straight from the cpu address
  assign direct_sel  = (state == st_idle);
  // first write goes back to the base halfword
  assign delayed_sel = (state == st_write) && (cnt == '0);

  assign modified_address = delayed_sel ? delayed_buf : added_address;
  assign to_mem_address   = direct_sel ? address[addr_width:1] : modified_address;

  // ####################
  // sequencer
  // ####################

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      cnt         <= '0;
      is_load_reg <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            // slot 0 issued this cycle, next read is slot 1
            state       <= st_read;
            cnt         <= cnt_width'(1);
            is_load_reg <= load;
          end
        end
        st_read: begin
          if (cnt != n_reg) begin
            cnt <= cnt + 1'b1;
          end else if (is_load_reg) begin
            state <= st_done;
          end else begin
            state <= st_write;
            cnt   <= '0;
          end
        end
        st_write: begin
          if (cnt == n_reg - 1'b1) begin
            state <= st_done;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // memory strobes
  assign to_mem_read_enable  = accept || ((state == st_read) && (cnt != n_reg));
  assign to_mem_write_enable = (state == st_write);
  assign to_mem_mem_enable   = to_mem_read_enable || to_mem_write_enable;
  assign to_mem_data         = write_half;

  // every read-state cycle sees data from the previous read
  assign capture = (state == st_read);
  // capture slot trails the counter by one, write slot is the counter
  assign slot    = capture ? 2'(cnt - 1'b1) : 2'(cnt);

  // last capture cycle of a load
  assign finish_load  = (state == st_read) && (cnt == n_reg) && is_load_reg;
  assign output_valid = (state == st_done) && is_load_reg;
  assign write_ready  = (state == st_done) && !is_load_reg;

  // ####################
  // checks
  // ####################

  a_no_load_and_store: assert property (
    @(posedge clk) disable iff (rst) !(load && store)
  );

  a_legal_size: assert property (
    @(posedge clk) disable iff (rst) accept |-> (word_type != 2'b11)
  );

  a_no_read_write: assert property (
    @(posedge clk) disable iff (rst) !(to_mem_read_enable && to_mem_write_enable)
  );

endmodule

`default_nettype wire

/* src/mem_data_lanes.sv */
/* data lanes of the bridge: capture window for up to three halfwords,
   load byte extraction with sign/zero extension, store byte merge */

`default_nettype none

module mem_data_lanes (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           capture,
  input  wire  [1:0]                    slot,
  input  wire                           offset,
  input  mem_bridge_pkg::access_size_t  size,
  input  wire                           sign,
  input  wire                           finish_load,
  input  mem_bridge_pkg::halfword_t     from_mem_data,
  input  mem_bridge_pkg::word_t         data_in,
  output mem_bridge_pkg::word_t         data_out,
  output mem_bridge_pkg::halfword_t     write_half
);

  localparam int win_width = 16 * mem_bridge_pkg::max_halfwords;
  localparam int win_bytes = 2 * mem_bridge_pkg::max_halfwords;

  // slot 0 sits in the low halfword
  logic [win_width-1:0] window;
  // window as it looks after this cycle's capture
  logic [win_width-1:0] win_next;

  logic [31:0]          raw;
  mem_bridge_pkg::word_t load_value;

  logic [3:0]           size_bytes;
  logic [win_bytes-1:0] byte_mask;
  logic [win_width-1:0] bit_mask;
  logic [win_width-1:0] data_shift;
  logic [win_width-1:0] merged;

  // ####################
  // capture window
  // ####################

  always_comb begin
    win_next = window;
    // returning halfword drops into its slot
    if (capture) begin
      win_next[slot*16 +: 16] = from_mem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      window <= win_next;
    end
  end

  // ####################
  // load path
  // ####################

  // little endian, first byte of the access is at byte offset 0 or 1
  // uses win_next so the last halfword can be used in its capture cycle
  assign raw = win_next[{offset, 3'b000} +: 32];

  always_comb begin
    case (size)
      mem_bridge_pkg::size_byte: begin
        load_value = sign ? {{24{raw[7]}}, raw[7:0]} : {24'h000000, raw[7:0]};
      end
      mem_bridge_pkg::size_half: begin
        load_value = sign ? {{16{raw[15]}}, raw[15:0]} : {16'h0000, raw[15:0]};
      end
      default: begin
        load_value = raw;
      end
    endcase
  end

  // result register, holds until the next finished load
  always_ff @(posedge clk) begin
    if (rst) begin
      data_out <= '0;
    end else if (finish_load) begin
      data_out <= load_value;
    end
  end

  // ####################
  // store merge
  // ####################

  // bytes written by the store, before shifting to the offset
  always_comb begin
    case (size)
      mem_bridge_pkg::size_byte: size_bytes = 4'b0001;
      mem_bridge_pkg::size_half: size_bytes = 4'b0011;
      mem_bridge_pkg::size_word: size_bytes = 4'b1111;
      default:                   size_bytes = 4'b0000;
    endcase
  end

  assign byte_mask  = win_bytes'(size_bytes) << offset;
  assign data_shift = win_width'(data_in) << {offset, 3'b000};

  // byte mask widened to one bit per data bit
  always_comb begin
    for (int i = 0; i < win_bytes; i++) begin
      bit_mask[i*8 +: 8] = {8{byte_mask[i]}};
    end
  end

  // new bytes over the old ones, untouched bytes keep the read value
  assign merged     = (window & ~bit_mask) | (data_shift & bit_mask);
  assign write_half = merged[slot*16 +: 16];

  // window has three slots only
  a_slot_range: assert property (
    @(posedge clk) disable iff (rst) capture |-> (slot <= 2'd2)
  );

endmodule

`default_nettype wire

/* src/sram_halfword.sv */
/* single-port synchronous sram of 16-bit halfwords
   one-cycle registered read, write at the clock edge */

`default_nettype none

module sram_halfword #(
  parameter int addr_width = 12
) (
  input  wire                           clk,
  input  wire                           mem_enable,
  input  wire                           read_enable,
  input  wire                           write_enable,
  input  wire  [addr_width-1:0]         address,
  input  mem_bridge_pkg::halfword_t     write_data,
  output mem_bridge_pkg::halfword_t     read_data
);

  localparam int depth = 2 ** addr_width;

  // storage array, contents are undefined until written
  mem_bridge_pkg::halfword_t mem [depth];

  // ####################
  // write port
  // ####################

  always_ff @(posedge clk) begin
    if (mem_enable && write_enable) begin
      mem[address] <= write_data;
    end
  end

  // ####################
  // read port
  // ####################

  // output register only loads on an enabled read
  // otherwise it keeps the last value read
  always_ff @(posedge clk) begin
    if (mem_enable && read_enable) begin
      read_data <= mem[address];
    end
  end

endmodule

`default_nettype wire

/* src/mem_bridge_pkg.sv */
/* shared types and limits for the halfword memory bridge:
   access size encoding, halfword and word data types, halfword count limit */

`default_nettype none

package mem_bridge_pkg;

  // ####################
  // access size
  // ####################

  // encoding seen on the cpu side, 2'b11 is not a legal request
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } access_size_t;

  // ####################
  // data types
  // ####################

  // one sram location
  typedef logic [15:0] halfword_t;

  // cpu load/store data
  typedef logic [31:0] word_t;

  // a misaligned word spans three halfwords, nothing spans more
  localparam int max_halfwords = 3;

endpackage

`default_nettype wire
